// File: design/cic_pkg.sv
`default_nettype none

package cic_pkg;

    // Bus widths.
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int SEL_W = DATA_W / 8;

    // Program/data RAM, word indexed by address bits 10:2.
    localparam int RAM_WORDS = 512;
    localparam int RAM_AW = $clog2(RAM_WORDS);

    // Region select, address bits 31:30.
    localparam logic [1:0] REGION_RAM = 2'b10;
    localparam logic [1:0] REGION_REG = 2'b11;

    // Register offsets, address bits 3:2.
    localparam logic [1:0] REG_CFG_HI = 2'd0;
    localparam logic [1:0] REG_CFG_LO = 2'd1;
    localparam logic [1:0] REG_CTRL = 2'd2;
    localparam logic [1:0] REG_DEBUG = 2'd3;

    // Written as control.
    typedef struct packed {
        logic [24:0] reserved_hi;
        logic invalid_region;
        logic timer_clear;
        logic timer_start;
        logic [2:0] reserved_lo;
        logic dq_out;
    } cic_ctrl_t;

    // Read back as status.
    typedef struct packed {
        logic [27:0] reserved;
        logic timer_elapsed;
        logic cic_reset;
        logic cic_clk;
        logic cic_dq;
    } cic_status_t;

    typedef union packed {
        cic_ctrl_t ctrl;
        cic_status_t status;
    } cic_ctrl_word_u;

endpackage

`default_nettype wire

// File: design/cic_reg_if.sv
`timescale 1ns/10ps
`default_nettype none

// One register access per valid cycle.
interface cic_reg_if;

    logic valid;
    logic write;
    logic [1:0] offset;
    logic [cic_pkg::DATA_W-1:0] wdata;
    logic [cic_pkg::DATA_W-1:0] rdata;

    modport master (
        output valid,
        output write,
        output offset,
        output wdata,
        input rdata
    );

    modport slave (
        input valid,
        input write,
        input offset,
        input wdata,
        output rdata
    );

endinterface

`default_nettype wire

// File: design/cic_pins.sv
`timescale 1ns/10ps
`default_nettype none

module cic_pins #(
    parameter int SYNC_STAGES = 2
) (
    input wire logic clk,
    input wire logic reset,
    input wire logic i_n64_reset,
    input wire logic i_cic_clk,
    input wire logic i_cic_dq,
    input wire logic i_si_clk,
    input wire logic i_dq_out,
    output logic o_cic_reset,
    output logic o_cic_clk,
    output logic o_cic_dq,
    output logic o_si_rise,
    output logic o_dq_oe
);

    logic [3:0] sync_q [SYNC_STAGES];
    logic [3:0] pins_s;
    logic si_last_q;
    logic dq_out_q;

    // Bit order is si_clk, dq, cic_clk, reset.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= {i_si_clk, i_cic_dq, i_cic_clk, i_n64_reset};
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign pins_s = sync_q[SYNC_STAGES-1];
    assign o_cic_reset = pins_s[0];
    assign o_cic_clk = pins_s[1];
    assign o_cic_dq = pins_s[2];

    always_ff @(posedge clk) begin
        if (reset) begin
            si_last_q <= 1'b0;
        end else begin
            si_last_q <= pins_s[3];
        end
    end

    // Edges only count while the console is out of reset.
    assign o_si_rise = pins_s[0] && !si_last_q && pins_s[3];

    // Data out is retimed once more before the pull-low enable.
    always_ff @(posedge clk) begin
        if (reset) begin
            dq_out_q <= 1'b1;
            o_dq_oe <= 1'b0;
        end else begin
            dq_out_q <= i_dq_out;
            o_dq_oe <= ~dq_out_q;
        end
    end

endmodule

`default_nettype wire

// File: design/cic_timer.sv
`timescale 1ns/10ps
`default_nettype none

module cic_timer #(
    parameter int DIV_W = 8,
    parameter logic [11:0] TIMEOUT_TICKS = 12'd3815
) (
    input wire logic clk,
    input wire logic reset,
    input wire logic i_tick,
    input wire logic i_start,
    input wire logic i_clear,
    output logic o_elapsed
);

    localparam int CNT_W = $bits(TIMEOUT_TICKS);

    logic [DIV_W-1:0] div_q;
    logic [CNT_W-1:0] count_q;
    logic div_wrap;

    assign div_wrap = i_tick && (&div_q);

    // Clear has priority over start.
    always_ff @(posedge clk) begin
        if (reset || i_clear) begin
            div_q <= '0;
            count_q <= '0;
            o_elapsed <= 1'b0;
        end else if (i_start) begin
            div_q <= '0;
            count_q <= TIMEOUT_TICKS;
            o_elapsed <= 1'b0;
        end else begin
            if (i_tick) begin
                div_q <= div_q + 1'b1;
            end
            if (div_wrap && (count_q != '0)) begin
                count_q <= count_q - 1'b1;
                // Last step down to zero.
                if (count_q == CNT_W'(1)) begin
                    o_elapsed <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/cic_regs.sv
`timescale 1ns/10ps
`default_nettype none

module cic_regs (
    input wire logic clk,
    input wire logic reset,
    cic_reg_if.slave bus,
    input wire logic i_cic_reset,
    input wire logic i_cic_clk,
    input wire logic i_cic_dq,
    input wire logic i_timer_elapsed,
    input wire logic i_cfg_disabled,
    input wire logic i_cfg_64dd,
    input wire logic i_cfg_region,
    input wire logic [7:0] i_cfg_seed,
    input wire logic [47:0] i_cfg_checksum,
    output logic o_dq_out,
    output logic o_timer_start,
    output logic o_timer_clear,
    output logic o_invalid_region,
    output logic [3:0] o_debug
);

    cic_pkg::cic_ctrl_word_u ctrl_wr;
    cic_pkg::cic_ctrl_word_u status_rd;
    logic ctrl_we;
    logic debug_we;

    assign ctrl_wr = bus.wdata;
    assign ctrl_we = bus.valid && bus.write && (bus.offset == cic_pkg::REG_CTRL);
    assign debug_we = bus.valid && bus.write && (bus.offset == cic_pkg::REG_DEBUG);

    // Control bits are single-cycle pulses.
    always_ff @(posedge clk) begin
        if (reset) begin
            o_timer_start <= 1'b0;
            o_timer_clear <= 1'b0;
            o_invalid_region <= 1'b0;
            o_debug <= 4'd0;
        end else begin
            o_timer_start <= ctrl_we && ctrl_wr.ctrl.timer_start;
            o_timer_clear <= ctrl_we && ctrl_wr.ctrl.timer_clear;
            o_invalid_region <= ctrl_we && ctrl_wr.ctrl.invalid_region;
            if (debug_we) begin
                o_debug <= bus.wdata[3:0];
            end
        end
    end

    // Pin released while the console holds reset.
    always_ff @(posedge clk) begin
        if (reset || !i_cic_reset) begin
            o_dq_out <= 1'b1;
        end else if (ctrl_we) begin
            o_dq_out <= ctrl_wr.ctrl.dq_out;
        end
    end

    always_comb begin
        status_rd = '0;
        status_rd.status.timer_elapsed = i_timer_elapsed;
        status_rd.status.cic_reset = i_cic_reset;
        status_rd.status.cic_clk = i_cic_clk;
        status_rd.status.cic_dq = i_cic_dq;
    end

    always_comb begin
        case (bus.offset)
            cic_pkg::REG_CFG_HI: bus.rdata = {
                i_cfg_disabled,
                i_cfg_64dd,
                i_cfg_region,
                5'd0,
                i_cfg_seed,
                i_cfg_checksum[47:32]
            };
            cic_pkg::REG_CFG_LO: bus.rdata = i_cfg_checksum[31:0];
            cic_pkg::REG_CTRL: bus.rdata = status_rd;
            default: bus.rdata = {28'd0, o_debug};
        endcase
    end

endmodule

`default_nettype wire

// File: design/cic_bus_fabric.sv
`timescale 1ns/10ps
`default_nettype none

module cic_bus_fabric (
    input wire logic clk,
    input wire logic reset,
    input wire logic i_ibus_cyc,
    input wire logic [cic_pkg::ADDR_W-1:0] i_ibus_adr,
    output logic [cic_pkg::DATA_W-1:0] o_ibus_rdt,
    output logic o_ibus_ack,
    input wire logic i_dbus_cyc,
    input wire logic i_dbus_we,
    input wire logic [cic_pkg::ADDR_W-1:0] i_dbus_adr,
    input wire logic [cic_pkg::DATA_W-1:0] i_dbus_dat,
    input wire logic [cic_pkg::SEL_W-1:0] i_dbus_sel,
    output logic [cic_pkg::DATA_W-1:0] o_dbus_rdt,
    output logic o_dbus_ack,
    cic_reg_if.master regs
);

    localparam int AW = cic_pkg::RAM_AW;

    logic [cic_pkg::DATA_W-1:0] ram [cic_pkg::RAM_WORDS];
    logic [cic_pkg::DATA_W-1:0] ram_q;
    logic [cic_pkg::DATA_W-1:0] reg_rdata_q;
    logic [AW-1:0] ram_addr;
    logic [1:0] dbus_region;
    logic [1:0] dbus_region_q;
    logic ibus_gnt;
    logic dbus_gnt;
    logic ram_en;
    logic ram_we;

    // A master in its ack cycle is not granted again.
    assign ibus_gnt = i_ibus_cyc && !o_ibus_ack;
    assign dbus_gnt = i_dbus_cyc && !o_dbus_ack && !ibus_gnt;

    assign dbus_region = i_dbus_adr[cic_pkg::ADDR_W-1 -: 2];
    assign ram_addr = ibus_gnt ? i_ibus_adr[AW+1:2] : i_dbus_adr[AW+1:2];
    assign ram_en = ibus_gnt || (dbus_gnt && (dbus_region == cic_pkg::REGION_RAM));
    assign ram_we = dbus_gnt && i_dbus_we && (dbus_region == cic_pkg::REGION_RAM);

    always_ff @(posedge clk) begin
        if (ram_en) begin
            ram_q <= ram[ram_addr];
        end
        for (int b = 0; b < cic_pkg::SEL_W; b++) begin
            if (ram_we && i_dbus_sel[b]) begin
                ram[ram_addr][8*b +: 8] <= i_dbus_dat[8*b +: 8];
            end
        end
    end

    assign regs.valid = dbus_gnt && (dbus_region == cic_pkg::REGION_REG);
    assign regs.write = i_dbus_we;
    assign regs.offset = i_dbus_adr[3:2];
    assign regs.wdata = i_dbus_dat;

    always_ff @(posedge clk) begin
        if (regs.valid) begin
            reg_rdata_q <= regs.rdata;
        end
        if (dbus_gnt) begin
            dbus_region_q <= dbus_region;
        end
    end

    // Ack one clock after the grant.
    always_ff @(posedge clk) begin
        if (reset) begin
            o_ibus_ack <= 1'b0;
            o_dbus_ack <= 1'b0;
        end else begin
            o_ibus_ack <= ibus_gnt;
            o_dbus_ack <= dbus_gnt;
        end
    end

    assign o_ibus_rdt = ram_q;

    // Unmapped regions read as zero.
    always_comb begin
        case (dbus_region_q)
            cic_pkg::REGION_RAM: o_dbus_rdt = ram_q;
            cic_pkg::REGION_REG: o_dbus_rdt = reg_rdata_q;
            default: o_dbus_rdt = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: design/cic_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

module cic_subsystem #(
    parameter int SYNC_STAGES = 2,
    parameter int DIV_W = 8,
    parameter logic [11:0] TIMEOUT_TICKS = 12'd3815
) (
    input wire logic clk,
    input wire logic reset,

    input wire logic i_ibus_cyc,
    input wire logic [cic_pkg::ADDR_W-1:0] i_ibus_adr,
    output logic [cic_pkg::DATA_W-1:0] o_ibus_rdt,
    output logic o_ibus_ack,

    input wire logic i_dbus_cyc,
    input wire logic i_dbus_we,
    input wire logic [cic_pkg::ADDR_W-1:0] i_dbus_adr,
    input wire logic [cic_pkg::DATA_W-1:0] i_dbus_dat,
    input wire logic [cic_pkg::SEL_W-1:0] i_dbus_sel,
    output logic [cic_pkg::DATA_W-1:0] o_dbus_rdt,
    output logic o_dbus_ack,

    input wire logic i_n64_reset,
    input wire logic i_cic_clk,
    input wire logic i_cic_dq,
    input wire logic i_si_clk,
    output logic o_cic_dq_oe,

    input wire logic i_cfg_disabled,
    input wire logic i_cfg_64dd,
    input wire logic i_cfg_region,
    input wire logic [7:0] i_cfg_seed,
    input wire logic [47:0] i_cfg_checksum,
    output logic o_cic_invalid_region,
    output logic [3:0] o_cic_debug
);

    cic_reg_if regs_if ();

    logic cic_reset;
    logic cic_clk;
    logic cic_dq;
    logic si_rise;
    logic dq_out;
    logic timer_start;
    logic timer_clear;
    logic timer_elapsed;

    cic_bus_fabric fabric_i (
        .clk(clk),
        .reset(reset),
        .i_ibus_cyc(i_ibus_cyc),
        .i_ibus_adr(i_ibus_adr),
        .o_ibus_rdt(o_ibus_rdt),
        .o_ibus_ack(o_ibus_ack),
        .i_dbus_cyc(i_dbus_cyc),
        .i_dbus_we(i_dbus_we),
        .i_dbus_adr(i_dbus_adr),
        .i_dbus_dat(i_dbus_dat),
        .i_dbus_sel(i_dbus_sel),
        .o_dbus_rdt(o_dbus_rdt),
        .o_dbus_ack(o_dbus_ack),
        .regs(regs_if.master)
    );

    cic_regs regs_i (
        .clk(clk),
        .reset(reset),
        .bus(regs_if.slave),
        .i_cic_reset(cic_reset),
        .i_cic_clk(cic_clk),
        .i_cic_dq(cic_dq),
        .i_timer_elapsed(timer_elapsed),
        .i_cfg_disabled(i_cfg_disabled),
        .i_cfg_64dd(i_cfg_64dd),
        .i_cfg_region(i_cfg_region),
        .i_cfg_seed(i_cfg_seed),
        .i_cfg_checksum(i_cfg_checksum),
        .o_dq_out(dq_out),
        .o_timer_start(timer_start),
        .o_timer_clear(timer_clear),
        .o_invalid_region(o_cic_invalid_region),
        .o_debug(o_cic_debug)
    );

    cic_pins #(
        .SYNC_STAGES(SYNC_STAGES)
    ) pins_i (
        .clk(clk),
        .reset(reset),
        .i_n64_reset(i_n64_reset),
        .i_cic_clk(i_cic_clk),
        .i_cic_dq(i_cic_dq),
        .i_si_clk(i_si_clk),
        .i_dq_out(dq_out),
        .o_cic_reset(cic_reset),
        .o_cic_clk(cic_clk),
        .o_cic_dq(cic_dq),
        .o_si_rise(si_rise),
        .o_dq_oe(o_cic_dq_oe)
    );

    cic_timer #(
        .DIV_W(DIV_W),
        .TIMEOUT_TICKS(TIMEOUT_TICKS)
    ) timer_i (
        .clk(clk),
        .reset(reset),
        .i_tick(si_rise),
        .i_start(timer_start),
        .i_clear(timer_clear),
        .o_elapsed(timer_elapsed)
    );

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD_NS = 50
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // 100 ns period.
    always #(HALF_PERIOD_NS) clk = ~clk;

endmodule

`default_nettype wire

// File: bench/cic_subsystem_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cic_subsystem_tb;

    localparam int SYNC = 2;
    localparam int RAM_TESTS = 8;
    localparam int EDGE_CYCLES = 4;
    // About three cycles per bus access, four cycles per serial-clock edge.
    localparam int TEST_CYCLES = RAM_TESTS * 4 * 3 + 20 + 20 + 60 + 24 * EDGE_CYCLES + 80;
    localparam int LIMIT_CYCLES = 2 * TEST_CYCLES + 100;

    logic clk;
    logic reset;
    logic i_ibus_cyc;
    logic [31:0] i_ibus_adr;
    logic [31:0] o_ibus_rdt;
    logic o_ibus_ack;
    logic i_dbus_cyc;
    logic i_dbus_we;
    logic [31:0] i_dbus_adr;
    logic [31:0] i_dbus_dat;
    logic [3:0] i_dbus_sel;
    logic [31:0] o_dbus_rdt;
    logic o_dbus_ack;
    logic i_n64_reset;
    logic i_cic_clk;
    logic i_cic_dq;
    logic i_si_clk;
    logic o_cic_dq_oe;
    logic i_cfg_disabled;
    logic i_cfg_64dd;
    logic i_cfg_region;
    logic [7:0] i_cfg_seed;
    logic [47:0] i_cfg_checksum;
    logic o_cic_invalid_region;
    logic [3:0] o_cic_debug;

    logic [31:0] ref_ram [cic_pkg::RAM_WORDS];
    logic [8:0] ram_idx [RAM_TESTS];
    int errors;
    int checks;
    int cycle_count;
    int pulse_count;

    tb_clock clock_i (
        .clk(clk)
    );

    cic_subsystem #(
        .SYNC_STAGES(SYNC),
        .DIV_W(2),
        .TIMEOUT_TICKS(12'd3)
    ) dut_i (
        .clk(clk),
        .reset(reset),
        .i_ibus_cyc(i_ibus_cyc),
        .i_ibus_adr(i_ibus_adr),
        .o_ibus_rdt(o_ibus_rdt),
        .o_ibus_ack(o_ibus_ack),
        .i_dbus_cyc(i_dbus_cyc),
        .i_dbus_we(i_dbus_we),
        .i_dbus_adr(i_dbus_adr),
        .i_dbus_dat(i_dbus_dat),
        .i_dbus_sel(i_dbus_sel),
        .o_dbus_rdt(o_dbus_rdt),
        .o_dbus_ack(o_dbus_ack),
        .i_n64_reset(i_n64_reset),
        .i_cic_clk(i_cic_clk),
        .i_cic_dq(i_cic_dq),
        .i_si_clk(i_si_clk),
        .o_cic_dq_oe(o_cic_dq_oe),
        .i_cfg_disabled(i_cfg_disabled),
        .i_cfg_64dd(i_cfg_64dd),
        .i_cfg_region(i_cfg_region),
        .i_cfg_seed(i_cfg_seed),
        .i_cfg_checksum(i_cfg_checksum),
        .o_cic_invalid_region(o_cic_invalid_region),
        .o_cic_debug(o_cic_debug)
    );

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > LIMIT_CYCLES) begin
            $display("Timeout: simulation ran past %0d clock cycles", LIMIT_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // High cycles of the invalid-region output.
    always @(negedge clk) begin
        if (o_cic_invalid_region === 1'b1) begin
            pulse_count++;
        end
    end

    function automatic logic [31:0] ram_addr(input logic [8:0] idx);
        return {cic_pkg::REGION_RAM, 19'd0, idx, 2'b00};
    endfunction

    function automatic logic [31:0] reg_addr(input logic [1:0] offset);
        return {cic_pkg::REGION_REG, 26'd0, offset, 2'b00};
    endfunction

    function automatic logic [31:0] merge_bytes(
        input logic [31:0] old_word,
        input logic [31:0] new_word,
        input logic [3:0] sel
    );
        logic [31:0] word;
        word = old_word;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                word[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return word;
    endfunction

    function automatic logic [31:0] ctrl_word(
        input logic start,
        input logic clear,
        input logic invalid,
        input logic dq
    );
        cic_pkg::cic_ctrl_word_u w;
        w = '0;
        w.ctrl.timer_start = start;
        w.ctrl.timer_clear = clear;
        w.ctrl.invalid_region = invalid;
        w.ctrl.dq_out = dq;
        return w;
    endfunction

    // Status expected from the pin levels now driven.
    function automatic logic [31:0] expect_status(input logic elapsed);
        cic_pkg::cic_ctrl_word_u w;
        w = '0;
        w.status.timer_elapsed = elapsed;
        w.status.cic_reset = i_n64_reset;
        w.status.cic_clk = i_cic_clk;
        w.status.cic_dq = i_cic_dq;
        return w;
    endfunction

    task automatic check_value(
        input string what,
        input logic [31:0] got,
        input logic [31:0] exp
    );
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Called at a falling edge, returns at the falling edge of the ack.
    task automatic dbus_access(
        input logic we,
        input logic [31:0] adr,
        input logic [31:0] dat,
        input logic [3:0] sel,
        output logic [31:0] rdt
    );
        i_dbus_cyc = 1'b1;
        i_dbus_we = we;
        i_dbus_adr = adr;
        i_dbus_dat = dat;
        i_dbus_sel = sel;
        do begin
            @(negedge clk);
        end while (!o_dbus_ack);
        rdt = o_dbus_rdt;
        i_dbus_cyc = 1'b0;
    endtask

    task automatic ibus_read(input logic [31:0] adr, output logic [31:0] rdt);
        i_ibus_cyc = 1'b1;
        i_ibus_adr = adr;
        do begin
            @(negedge clk);
        end while (!o_ibus_ack);
        rdt = o_ibus_rdt;
        i_ibus_cyc = 1'b0;
    endtask

    task automatic settle();
        repeat (SYNC + 2) @(negedge clk);
    endtask

    task automatic si_edges(input int count);
        repeat (count) begin
            i_si_clk = 1'b1;
            repeat (EDGE_CYCLES / 2) @(negedge clk);
            i_si_clk = 1'b0;
            repeat (EDGE_CYCLES / 2) @(negedge clk);
        end
    endtask

    task automatic wait_dq_oe(input logic level, input int max_cycles);
        int n;
        n = 0;
        while (o_cic_dq_oe !== level && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        checks++;
        assert (o_cic_dq_oe === level) else begin
            errors++;
            $display("Error at %0d ns: o_cic_dq_oe stayed %b", $time, o_cic_dq_oe);
        end
    endtask

    task automatic test_ram();
        logic [31:0] dat;
        logic [31:0] rdt;
        logic [3:0] sel;
        for (int i = 0; i < RAM_TESTS; i++) begin
            ram_idx[i] = 9'(i * 64) + 9'($urandom % 64);
            dat = $urandom;
            dbus_access(1'b1, ram_addr(ram_idx[i]), dat, 4'hf, rdt);
            ref_ram[ram_idx[i]] = dat;
            dat = $urandom;
            sel = 4'($urandom);
            dbus_access(1'b1, ram_addr(ram_idx[i]), dat, sel, rdt);
            ref_ram[ram_idx[i]] = merge_bytes(ref_ram[ram_idx[i]], dat, sel);
        end
        for (int i = 0; i < RAM_TESTS; i++) begin
            dbus_access(1'b0, ram_addr(ram_idx[i]), 32'd0, 4'h0, rdt);
            check_value("RAM data bus read", rdt, ref_ram[ram_idx[i]]);
            ibus_read(ram_addr(ram_idx[i]), rdt);
            check_value("RAM instruction bus read", rdt, ref_ram[ram_idx[i]]);
        end
    endtask

    task automatic test_arbitration();
        logic [31:0] ibus_data;
        logic [31:0] dbus_data;
        // Let the previous instruction ack pass so both requests meet in one cycle.
        @(negedge clk);
        i_ibus_cyc = 1'b1;
        i_ibus_adr = ram_addr(ram_idx[1]);
        i_dbus_cyc = 1'b1;
        i_dbus_we = 1'b0;
        i_dbus_adr = ram_addr(ram_idx[2]);
        do begin
            @(negedge clk);
        end while (!o_ibus_ack && !o_dbus_ack);
        checks++;
        assert (o_ibus_ack && !o_dbus_ack) else begin
            errors++;
            $display("Error at %0d ns: instruction bus was not acknowledged first", $time);
        end
        ibus_data = o_ibus_rdt;
        i_ibus_cyc = 1'b0;
        while (!o_dbus_ack) begin
            @(negedge clk);
        end
        dbus_data = o_dbus_rdt;
        i_dbus_cyc = 1'b0;
        check_value("arbitrated instruction read", ibus_data, ref_ram[ram_idx[1]]);
        check_value("arbitrated data read", dbus_data, ref_ram[ram_idx[2]]);
    endtask

    task automatic test_config();
        logic [31:0] rdt;
        logic [31:0] exp_hi;
        i_cfg_disabled = 1'($urandom);
        i_cfg_64dd = 1'($urandom);
        i_cfg_region = 1'($urandom);
        i_cfg_seed = 8'($urandom);
        i_cfg_checksum = {16'($urandom), 32'($urandom)};
        exp_hi = '0;
        exp_hi[31] = i_cfg_disabled;
        exp_hi[30] = i_cfg_64dd;
        exp_hi[29] = i_cfg_region;
        exp_hi[23:16] = i_cfg_seed;
        exp_hi[15:0] = i_cfg_checksum[47:32];
        dbus_access(1'b0, reg_addr(cic_pkg::REG_CFG_HI), 32'd0, 4'h0, rdt);
        check_value("REG_CFG_HI", rdt, exp_hi);
        dbus_access(1'b0, reg_addr(cic_pkg::REG_CFG_LO), 32'd0, 4'h0, rdt);
        check_value("REG_CFG_LO", rdt, i_cfg_checksum[31:0]);
        // Unmapped region still acks and reads zero.
        dbus_access(1'b0, 32'h4000_0000, 32'd0, 4'h0, rdt);
        check_value("unmapped region read", rdt, 32'd0);
    endtask

    task automatic test_data_pin();
        logic [31:0] rdt;
        i_n64_reset = 1'b1;
        settle();
        dbus_access(1'b1, reg_addr(cic_pkg::REG_CTRL), ctrl_word(0, 0, 0, 0), 4'hf, rdt);
        wait_dq_oe(1'b1, 8);
        i_n64_reset = 1'b0;
        wait_dq_oe(1'b0, 8);
        for (int k = 0; k < 4; k++) begin
            i_n64_reset = k[0];
            i_cic_clk = 1'($urandom);
            i_cic_dq = 1'($urandom);
            settle();
            dbus_access(1'b0, reg_addr(cic_pkg::REG_CTRL), 32'd0, 4'h0, rdt);
            check_value("status view of pins", rdt, expect_status(1'b0));
        end
    endtask

    task automatic test_timer_debug();
        logic [31:0] rdt;
        logic [31:0] dat;
        i_n64_reset = 1'b1;
        settle();
        dbus_access(1'b1, reg_addr(cic_pkg::REG_CTRL), ctrl_word(1, 0, 0, 1), 4'hf, rdt);
        si_edges(11);
        settle();
        dbus_access(1'b0, reg_addr(cic_pkg::REG_CTRL), 32'd0, 4'h0, rdt);
        check_value("status after 11 edges", rdt, expect_status(1'b0));
        si_edges(1);
        settle();
        dbus_access(1'b0, reg_addr(cic_pkg::REG_CTRL), 32'd0, 4'h0, rdt);
        check_value("status after 12 edges", rdt, expect_status(1'b1));
        dbus_access(1'b1, reg_addr(cic_pkg::REG_CTRL), ctrl_word(0, 1, 0, 1), 4'hf, rdt);
        dbus_access(1'b0, reg_addr(cic_pkg::REG_CTRL), 32'd0, 4'h0, rdt);
        check_value("status after clear", rdt, expect_status(1'b0));

        // Console held in reset, so no edge may count.
        i_n64_reset = 1'b0;
        settle();
        dbus_access(1'b1, reg_addr(cic_pkg::REG_CTRL), ctrl_word(1, 0, 0, 1), 4'hf, rdt);
        si_edges(12);
        settle();
        dbus_access(1'b0, reg_addr(cic_pkg::REG_CTRL), 32'd0, 4'h0, rdt);
        check_value("status with console in reset", rdt, expect_status(1'b0));

        dat = $urandom;
        dbus_access(1'b1, reg_addr(cic_pkg::REG_DEBUG), dat, 4'hf, rdt);
        check_value("o_cic_debug", {28'd0, o_cic_debug}, {28'd0, dat[3:0]});
        dbus_access(1'b0, reg_addr(cic_pkg::REG_DEBUG), 32'd0, 4'h0, rdt);
        check_value("REG_DEBUG readback", rdt, {28'd0, dat[3:0]});

        pulse_count = 0;
        dbus_access(1'b1, reg_addr(cic_pkg::REG_CTRL), ctrl_word(0, 0, 1, 1), 4'hf, rdt);
        repeat (4) @(negedge clk);
        check_value("invalid-region high cycles", 32'(pulse_count), 32'd1);
    endtask

    initial begin : main_seq
        int seed_value;
        seed_value = $urandom(45);
        errors = 0;
        checks = 0;
        pulse_count = 0;
        reset = 1'b1;
        i_ibus_cyc = 1'b0;
        i_ibus_adr = '0;
        i_dbus_cyc = 1'b0;
        i_dbus_we = 1'b0;
        i_dbus_adr = '0;
        i_dbus_dat = '0;
        i_dbus_sel = '0;
        i_n64_reset = 1'b0;
        i_cic_clk = 1'b0;
        i_cic_dq = 1'b0;
        i_si_clk = 1'b0;
        i_cfg_disabled = 1'b0;
        i_cfg_64dd = 1'b0;
        i_cfg_region = 1'b0;
        i_cfg_seed = '0;
        i_cfg_checksum = '0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        test_ram();
        test_arbitration();
        test_config();
        test_data_pin();
        test_timer_debug();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: cic_link.f
design/cic_pkg.sv
design/cic_reg_if.sv
design/cic_pins.sv
design/cic_timer.sv
design/cic_regs.sv
design/cic_bus_fabric.sv
design/cic_subsystem.sv
bench/tb_clock.sv
bench/cic_subsystem_tb.sv
